// ==== src/dap_pkg.sv ====
package dap_pkg;

    // ------------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------------

    // One byte of the request or response stream
    typedef logic [7:0]  byte_t;

    // One AHB data word
    typedef logic [31:0] word_t;

    // Byte lanes of one AHB transfer
    typedef logic [3:0]  strobe_t;

    // Byte offset inside a response group, also used for the group length
    typedef logic [9:0]  resp_addr_t;

    // Command state machine
    typedef enum logic [1:0] {
        st_read_cmd,
        st_read_num,
        st_run,
        st_finish
    } cmd_state_t;

    // ------------------------------------------------------------------------
    // Command codes decoded in hardware
    // ------------------------------------------------------------------------
    localparam byte_t cmd_transfer_abort = 8'h07;
    localparam byte_t cmd_delay          = 8'h09;
    localparam byte_t cmd_queue          = 8'h7E;
    localparam byte_t cmd_execute        = 8'h7F;

    // Register offsets
    localparam word_t reg_cr     = 32'h0000_0000;
    localparam word_t reg_time   = 32'h0000_0004;
    localparam word_t reg_sr     = 32'h0000_0008;
    localparam word_t reg_dr     = 32'h0000_000C;
    localparam word_t reg_curcmd = 32'h0000_0010;

    // Longest wait of a data register read on an empty stream
    localparam int dr_timeout_cycles = 16;

endpackage

// ==== src/dap_timer.sv ====
`timescale 1ns/10ps

module dap_timer import dap_pkg::*; #(
    parameter int clk_mhz = 60
) (
    input  logic  hclk,
    input  logic  hresetn,
    input  logic  time_clear,
    output word_t clk_count,
    output logic  us_tick
);

    localparam int div_width = $clog2(clk_mhz + 1);

    // Cycle divider for the microsecond tick
    logic [div_width-1:0] div_q;

    // Last cycle of each microsecond
    assign us_tick = (div_q == div_width'(clk_mhz - 1));

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            clk_count <= '0;
            div_q     <= '0;
        end else if (time_clear) begin
            // TIME write restarts both counters
            clk_count <= '0;
            div_q     <= '0;
        end else begin
            clk_count <= clk_count + 1'b1;
            if (us_tick) begin
                div_q <= '0;
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

endmodule

// ==== src/dap_ahb_regs.sv ====
`timescale 1ns/10ps

module dap_ahb_regs import dap_pkg::*; #(
    parameter int addr_width = 12
) (
    input  logic                  hclk,
    input  logic                  hresetn,
    input  logic                  hsel,
    input  logic [addr_width-1:0] haddr,
    input  logic [1:0]            htrans,
    input  logic [2:0]            hsize,
    input  logic                  hwrite,
    input  logic                  hready,
    input  word_t                 hwdata,
    output logic                  hreadyout,
    output word_t                 hrdata,
    input  word_t                 clk_count,
    input  logic                  helper_active,
    input  byte_t                 cur_cmd,
    input  logic                  in_valid,
    input  byte_t                 in_data,
    output logic                  enable,
    output logic                  int_en,
    output logic                  time_clear,
    output logic                  dr_write,
    output logic                  dr_read,
    output logic                  sr_clear,
    output byte_t                 wdata_byte
);

    localparam int tmo_width = $clog2(dr_timeout_cycles) + 1;

    logic                  trans_req;
    logic [addr_width-1:0] addr_q;
    logic                  read_en;
    logic                  write_en;
    strobe_t               strobe_nxt;
    strobe_t               strobe_q;
    word_t                 addr_word;
    word_t                 ctrl_q;
    logic [tmo_width-1:0]  tmo_q;
    logic                  timed_out;

    // ------------------------------------------------------------------------
    // Address phase
    // ------------------------------------------------------------------------

    // Only NONSEQ and SEQ transfers start an access
    assign trans_req = hready & hsel & htrans[1];

    always_comb begin
        case (hsize)
            3'b000:  strobe_nxt = strobe_t'(4'b0001) << haddr[1:0];
            3'b001:  strobe_nxt = haddr[1] ? 4'b1100 : 4'b0011;
            default: strobe_nxt = 4'b1111;
        endcase
    end

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            addr_q   <= '0;
            strobe_q <= '0;
            read_en  <= 1'b0;
            write_en <= 1'b0;
        end else begin
            if (trans_req) begin
                addr_q   <= haddr;
                strobe_q <= strobe_nxt;
            end
            // Data phase ends on hready
            if (hready) begin
                read_en  <= trans_req & ~hwrite;
                write_en <= trans_req & hwrite;
            end
        end
    end

    // Word aligned register offset of the data phase
    assign addr_word = word_t'({addr_q[addr_width-1:2], 2'b00});

    // ------------------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------------------
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            ctrl_q <= '0;
        end else if (write_en && addr_word == reg_cr) begin
            for (int i = 0; i < 4; i++) begin
                if (strobe_q[i]) begin
                    ctrl_q[8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    assign enable     = ctrl_q[0];
    assign int_en     = ctrl_q[31];
    assign time_clear = write_en && (addr_word == reg_time);
    assign dr_write   = write_en && (addr_word == reg_dr) && strobe_q[0];
    assign sr_clear   = write_en && (addr_word == reg_sr) && strobe_q[3] && hwdata[31];
    assign dr_read    = read_en && (addr_word == reg_dr);
    assign wdata_byte = hwdata[7:0];

    // ------------------------------------------------------------------------
    // Read data and wait states
    // ------------------------------------------------------------------------

    // Cycles spent by a DR read on an empty stream
    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            tmo_q <= '0;
        end else if (dr_read && !hreadyout) begin
            tmo_q <= tmo_q + 1'b1;
        end else begin
            tmo_q <= '0;
        end
    end

    assign timed_out = (tmo_q == tmo_width'(dr_timeout_cycles));
    assign hreadyout = ~dr_read | in_valid | timed_out;

    always_comb begin
        hrdata = '0;
        if (read_en) begin
            case (addr_word)
                reg_cr:     hrdata = ctrl_q;
                reg_time:   hrdata = clk_count;
                reg_sr:     hrdata = {helper_active, 31'd0};
                // Bit 8 tells whether the byte was valid
                reg_dr:     hrdata = {23'd0, in_valid, in_data};
                reg_curcmd: hrdata = {24'd0, cur_cmd};
                default:    hrdata = '0;
            endcase
        end
    end

endmodule

// ==== src/dap_cmd_fsm.sv ====
`timescale 1ns/10ps

module dap_cmd_fsm import dap_pkg::*; (
    input  logic       hclk,
    input  logic       hresetn,
    input  logic       enable,
    input  logic       in_valid,
    input  byte_t      in_data,
    input  logic       dr_read,
    input  logic       delay_ready,
    input  logic       helper_done,
    input  logic       delay_done,
    input  logic       almost_full,
    input  logic       helper_we,
    input  resp_addr_t helper_addr,
    input  byte_t      helper_data,
    input  resp_addr_t helper_len,
    input  logic       delay_we,
    input  resp_addr_t delay_addr,
    input  byte_t      delay_data,
    output logic       helper_start,
    output logic       delay_start,
    output logic       in_ready,
    output byte_t      cur_cmd,
    output logic       resp_we,
    output resp_addr_t resp_addr,
    output byte_t      resp_data,
    output resp_addr_t resp_len,
    output logic       group_finish,
    output logic       packet_finish
);

    // Delay answers with the echo and one status byte
    localparam resp_addr_t delay_len = 10'd2;

    cmd_state_t state_q;
    byte_t      num_q;
    logic       group_q;
    logic       packet_q;
    byte_t      dec_cmd;
    logic       is_abort;
    logic       is_exec;
    logic       is_delay;
    logic       we_sel;
    logic       gf_sel;

    // Decode the incoming byte while idle, the held command otherwise
    assign dec_cmd  = (state_q == st_read_cmd) ? in_data : cur_cmd;
    assign is_abort = (dec_cmd == cmd_transfer_abort);
    assign is_exec  = (dec_cmd == cmd_execute) || (dec_cmd == cmd_queue);
    assign is_delay = (dec_cmd == cmd_delay);

    // Anything not decoded here goes to the firmware
    assign delay_start  = enable && (state_q == st_run) && is_delay;
    assign helper_start = enable && (state_q == st_run) && !is_delay;

    assign in_ready = enable && ((state_q == st_read_cmd) || (state_q == st_read_num) ||
                                 delay_ready || dr_read);

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state_q  <= st_read_cmd;
            cur_cmd  <= '0;
            num_q    <= '0;
            group_q  <= 1'b0;
            packet_q <= 1'b0;
        end else if (!enable) begin
            state_q  <= st_read_cmd;
            num_q    <= '0;
            group_q  <= 1'b0;
            packet_q <= 1'b0;
        end else begin
            group_q  <= 1'b0;
            packet_q <= 1'b0;
            case (state_q)
                st_read_cmd: if (in_valid) begin
                    cur_cmd <= in_data;
                    if (is_abort) begin
                        state_q <= st_read_cmd;
                    end else if (is_exec) begin
                        state_q <= st_read_num;
                    end else begin
                        state_q <= st_run;
                    end
                end
                st_read_num: if (in_valid) begin
                    num_q   <= in_data;
                    state_q <= st_read_cmd;
                end
                st_run: if (is_delay ? delay_done : helper_done) begin
                    group_q <= 1'b1;
                    state_q <= st_finish;
                end
                default: if (!almost_full) begin
                    // Last command of the packet
                    if (num_q <= 8'd1) begin
                        num_q    <= '0;
                        packet_q <= 1'b1;
                    end else begin
                        num_q <= num_q - 1'b1;
                    end
                    state_q <= st_read_cmd;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------------
    always_comb begin
        we_sel    = 1'b0;
        gf_sel    = group_q;
        resp_addr = '0;
        resp_data = in_data;
        resp_len  = resp_addr_t'(1);
        case (state_q)
            // Echo of the command byte, a group of its own
            st_read_cmd: begin
                we_sel = in_valid && !is_abort;
                gf_sel = we_sel;
            end
            st_read_num: begin
                we_sel = in_valid;
                gf_sel = in_valid;
            end
            default: if (is_delay) begin
                we_sel    = delay_we;
                resp_addr = delay_addr;
                resp_data = delay_data;
                resp_len  = delay_len;
            end else begin
                we_sel    = helper_we;
                resp_addr = helper_addr;
                resp_data = helper_data;
                resp_len  = helper_len;
            end
        endcase
    end

    assign resp_we       = enable & we_sel;
    assign group_finish  = enable & gf_sel;
    assign packet_finish = enable & packet_q;

endmodule

// ==== src/dap_mcu_helper.sv ====
`timescale 1ns/10ps

module dap_mcu_helper import dap_pkg::*; (
    input  logic       hclk,
    input  logic       hresetn,
    input  logic       start,
    input  logic       dr_write,
    input  logic       sr_clear,
    input  byte_t      wdata_byte,
    output logic       we,
    output resp_addr_t addr,
    output byte_t      data,
    output resp_addr_t len,
    output logic       done
);

    // Bytes written by firmware so far
    resp_addr_t count_q;

    assign we   = start & dr_write;
    assign addr = count_q;
    assign data = wdata_byte;
    assign len  = count_q;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            count_q <= '0;
            done    <= 1'b0;
        end else if (!start) begin
            count_q <= '0;
            done    <= 1'b0;
        end else begin
            if (dr_write) begin
                count_q <= count_q + 1'b1;
            end
            // Firmware acknowledges the interrupt when its answer is complete
            if (sr_clear) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== src/dap_delay_worker.sv ====
`timescale 1ns/10ps

module dap_delay_worker import dap_pkg::*; (
    input  logic       hclk,
    input  logic       hresetn,
    input  logic       start,
    input  logic       us_tick,
    input  logic       in_valid,
    input  byte_t      in_data,
    output logic       in_ready,
    output logic       we,
    output resp_addr_t addr,
    output byte_t      data,
    output logic       done
);

    typedef enum logic [2:0] {
        dl_read_lo,
        dl_read_hi,
        dl_wait,
        dl_write,
        dl_done
    } delay_state_t;

    delay_state_t state_q;

    // Microseconds still to wait
    logic [15:0] count_q;

    assign in_ready = start && (state_q == dl_read_lo || state_q == dl_read_hi);
    assign we       = start && (state_q == dl_write);
    assign done     = start && (state_q == dl_done);

    // Status byte OK right after the echo
    assign addr = resp_addr_t'(1);
    assign data = 8'h00;

    always_ff @(posedge hclk or negedge hresetn) begin
        if (!hresetn) begin
            state_q <= dl_read_lo;
            count_q <= '0;
        end else if (!start) begin
            state_q <= dl_read_lo;
        end else begin
            case (state_q)
                // Count arrives little endian
                dl_read_lo: if (in_valid) begin
                    count_q[7:0] <= in_data;
                    state_q      <= dl_read_hi;
                end
                dl_read_hi: if (in_valid) begin
                    count_q[15:8] <= in_data;
                    state_q       <= dl_wait;
                end
                dl_wait: begin
                    if (count_q == 16'd0) begin
                        state_q <= dl_write;
                    end else if (us_tick) begin
                        count_q <= count_q - 1'b1;
                    end
                end
                dl_write: state_q <= dl_done;
                default:  state_q <= dl_done;
            endcase
        end
    end

endmodule

// ==== src/dap_controller.sv ====
`timescale 1ns/10ps

module dap_controller import dap_pkg::*; #(
    parameter int clk_mhz    = 60,
    parameter int addr_width = 12
) (
    input  logic                  hclk,
    input  logic                  hresetn,
    // AHB slave
    input  logic                  hsel,
    input  logic [addr_width-1:0] haddr,
    input  logic [1:0]            htrans,
    input  logic [2:0]            hsize,
    input  logic                  hwrite,
    input  logic                  hready,
    input  word_t                 hwdata,
    output logic                  hreadyout,
    output word_t                 hrdata,
    output logic                  intr,
    // Request stream
    input  logic                  in_valid,
    output logic                  in_ready,
    input  byte_t                 in_data,
    // Response port
    output logic                  resp_we,
    output resp_addr_t            resp_addr,
    output byte_t                 resp_data,
    output resp_addr_t            resp_len,
    output logic                  group_finish,
    output logic                  packet_finish,
    input  logic                  almost_full
);

    word_t      clk_count;
    logic       us_tick;
    logic       enable;
    logic       int_en;
    logic       time_clear;
    logic       dr_write;
    logic       dr_read;
    logic       sr_clear;
    byte_t      wdata_byte;
    byte_t      cur_cmd;
    logic       helper_start;
    logic       helper_we;
    resp_addr_t helper_addr;
    byte_t      helper_data;
    resp_addr_t helper_len;
    logic       helper_done;
    logic       delay_start;
    logic       delay_ready;
    logic       delay_we;
    resp_addr_t delay_addr;
    byte_t      delay_data;
    logic       delay_done;

    // Firmware is asked to handle the command
    assign intr = int_en & helper_start;

    dap_timer #(
        .clk_mhz(clk_mhz)
    ) u_timer (
        .hclk, .hresetn, .time_clear, .clk_count, .us_tick
    );

    dap_ahb_regs #(
        .addr_width(addr_width)
    ) u_regs (
        .hclk, .hresetn, .hsel, .haddr, .htrans, .hsize, .hwrite, .hready,
        .hwdata, .hreadyout, .hrdata, .clk_count,
        .helper_active(helper_start),
        .cur_cmd, .in_valid, .in_data, .enable, .int_en, .time_clear,
        .dr_write, .dr_read, .sr_clear, .wdata_byte
    );

    dap_cmd_fsm u_fsm (
        .hclk, .hresetn, .enable, .in_valid, .in_data, .dr_read, .delay_ready,
        .helper_done, .delay_done, .almost_full, .helper_we, .helper_addr,
        .helper_data, .helper_len, .delay_we, .delay_addr, .delay_data,
        .helper_start, .delay_start, .in_ready, .cur_cmd, .resp_we, .resp_addr,
        .resp_data, .resp_len, .group_finish, .packet_finish
    );

    dap_mcu_helper u_helper (
        .hclk, .hresetn,
        .start(helper_start),
        .dr_write, .sr_clear, .wdata_byte,
        .we(helper_we),
        .addr(helper_addr),
        .data(helper_data),
        .len(helper_len),
        .done(helper_done)
    );

    dap_delay_worker u_delay (
        .hclk, .hresetn,
        .start(delay_start),
        .us_tick, .in_valid, .in_data,
        .in_ready(delay_ready),
        .we(delay_we),
        .addr(delay_addr),
        .data(delay_data),
        .done(delay_done)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int period_ns   = 100,
    parameter int reset_count = 2
) (
    output logic hclk,
    output logic hresetn
);

    initial begin
        hclk = 1'b0;
        forever begin
            #(period_ns / 2) hclk = ~hclk;
        end
    end

    // Reset released just after a rising edge
    initial begin
        hresetn = 1'b0;
        repeat (reset_count) @(posedge hclk);
        #1 hresetn = 1'b1;
    end

endmodule

// ==== sim/tb_dap_controller.sv ====
`timescale 1ns/10ps

module tb_dap_controller import dap_pkg::*;;

    localparam int aw = 12;

    logic          hclk;
    logic          hresetn;
    logic          hsel;
    logic [aw-1:0] haddr;
    logic [1:0]    htrans;
    logic [2:0]    hsize;
    logic          hwrite;
    logic          hready;
    word_t         hwdata;
    logic          hreadyout;
    word_t         hrdata;
    logic          intr;
    logic          in_valid;
    logic          in_ready;
    byte_t         in_data;
    logic          resp_we;
    resp_addr_t    resp_addr;
    byte_t         resp_data;
    resp_addr_t    resp_len;
    logic          group_finish;
    logic          packet_finish;
    logic          almost_full;

    // Expected response traffic, filled before the stimulus
    resp_addr_t exp_addr[$];
    byte_t      exp_data[$];
    resp_addr_t exp_len[$];
    int         groups_seen = 0;
    int         packets_seen = 0;
    time        last_packet_time = 0;
    time        accept_time = 0;
    logic [31:0] lfsr_state = 32'h30ad6ba7;
    int         dly[4];
    longint     watchdog_ns = 1000000;
    // Wait states of the last bus phase
    int         last_wait = 0;

    tb_clock_gen #(.period_ns(100), .reset_count(2)) u_clk (.hclk, .hresetn);

    // Single slave on the bus
    assign hready = hreadyout;

    dap_controller #(.clk_mhz(10), .addr_width(aw)) uut (
        .hclk, .hresetn, .hsel, .haddr, .htrans, .hsize, .hwrite, .hready,
        .hwdata, .hreadyout, .hrdata, .intr, .in_valid, .in_ready, .in_data,
        .resp_we, .resp_addr, .resp_data, .resp_len, .group_finish,
        .packet_finish, .almost_full
    );

    // ------------------------------------------------------------------------
    // Failure reporting and compares
    // ------------------------------------------------------------------------
    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic fail_with(string msg);
        $display("%s at time %0t", msg, $time);
        abort_run();
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_byte(string name, byte_t got, byte_t exp);
        if (got !== exp) begin
            $display("error: time %0t %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_len(string name, resp_addr_t got, resp_addr_t exp);
        if (got !== exp) begin
            $display("error: time %0t %s got %0d expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // LFSR and reference functions
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'hA300_0000;
            end
            r = {r[30:0], lsb};
        end
        return r;
    endfunction

    // Byte lanes of one AHB write merged into the old register value
    function automatic word_t cr_after_write(word_t old, word_t wdata, logic [2:0] size,
                                             logic [1:0] offs);
        word_t res;
        logic  hit;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (size == 3'd0) begin
                hit = (i == int'(offs));
            end else if (size == 3'd1) begin
                hit = ((i / 2) == int'(offs[1]));
            end else begin
                hit = 1'b1;
            end
            if (hit) begin
                res[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return res;
    endfunction

    function automatic void expect_write(resp_addr_t a, byte_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endfunction

    // Groups produced by the hardware for one command byte
    function automatic void expect_response(byte_t cmd, byte_t num);
        if (cmd != cmd_transfer_abort) begin
            expect_write(resp_addr_t'(0), cmd);
            exp_len.push_back(resp_addr_t'(1));
        end
        if (cmd == cmd_delay) begin
            expect_write(resp_addr_t'(1), 8'h00);
            exp_len.push_back(resp_addr_t'(2));
        end else if (cmd == cmd_execute || cmd == cmd_queue) begin
            expect_write(resp_addr_t'(0), num);
            exp_len.push_back(resp_addr_t'(1));
        end
    endfunction

    // One packet ends once all commands of a batch are done
    function automatic int packet_due(int cmds_done, int n_cmds);
        return (cmds_done >= ((n_cmds == 0) ? 1 : n_cmds)) ? 1 : 0;
    endfunction

    // ------------------------------------------------------------------------
    // Response monitor
    // ------------------------------------------------------------------------
    always @(negedge hclk) begin
        if (hresetn) begin
            if (resp_we) begin
                if (exp_data.size() == 0) begin
                    fail_with("Response write that no command asked for");
                end else begin
                    check_len("resp_addr", resp_addr, exp_addr.pop_front());
                    check_byte("resp_data", resp_data, exp_data.pop_front());
                end
            end
            if (group_finish) begin
                if (exp_len.size() == 0) begin
                    fail_with("Group end that no command asked for");
                end else begin
                    check_len("resp_len", resp_len, exp_len.pop_front());
                    groups_seen++;
                end
            end
            if (packet_finish) begin
                packets_seen++;
                last_packet_time = $time;
            end
        end
    end

    // Watchdog sized from the drawn delays
    initial begin
        #1;
        #(watchdog_ns);
        fail_with("Timeout, the DUT stopped making progress");
    end

    // ------------------------------------------------------------------------
    // Bus and stream tasks
    // ------------------------------------------------------------------------
    task automatic wait_ready();
        last_wait = 0;
        @(negedge hclk);
        while (!hreadyout) begin
            last_wait++;
            @(negedge hclk);
        end
    endtask

    task automatic ahb_write(word_t addr, word_t data, logic [2:0] size);
        hsel   = 1'b1;
        haddr  = addr[aw-1:0];
        htrans = 2'b10;
        hsize  = size;
        hwrite = 1'b1;
        wait_ready();
        @(posedge hclk);
        #1;
        hsel   = 1'b0;
        htrans = 2'b00;
        hwrite = 1'b0;
        hwdata = data;
        wait_ready();
        @(posedge hclk);
        #1;
    endtask

    task automatic ahb_read(word_t addr, output word_t data);
        hsel   = 1'b1;
        haddr  = addr[aw-1:0];
        htrans = 2'b10;
        hsize  = 3'd2;
        hwrite = 1'b0;
        wait_ready();
        @(posedge hclk);
        #1;
        hsel   = 1'b0;
        htrans = 2'b00;
        wait_ready();
        data = hrdata;
        @(posedge hclk);
        #1;
    endtask

    task automatic send_byte(byte_t b);
        in_valid = 1'b1;
        in_data  = b;
        @(negedge hclk);
        while (!in_ready) @(negedge hclk);
        @(posedge hclk);
        accept_time = $time;
        #1;
        in_valid = 1'b0;
        in_data  = '0;
    endtask

    task automatic wait_packets(int n);
        while (packets_seen < n) @(posedge hclk);
        #1;
    endtask

    task automatic wait_groups(int n);
        while (groups_seen < n) @(posedge hclk);
        #1;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge hclk);
            #1;
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        word_t      cr_model;
        word_t      got;
        word_t      wd;
        logic [2:0] size;
        logic [1:0] offs;
        byte_t      b;
        int         k;
        int         n;
        int         base;
        int         g0;
        longint     elapsed;

        hsel        = 1'b0;
        haddr       = '0;
        htrans      = 2'b00;
        hsize       = 3'd0;
        hwrite      = 1'b0;
        hwdata      = '0;
        in_valid    = 1'b0;
        in_data     = '0;
        almost_full = 1'b0;

        for (int i = 0; i < 4; i++) begin
            dly[i] = int'(rand_bits(6)) % 40;
        end
        watchdog_ns = longint'(dly[0] + dly[1] + dly[2] + dly[3] + 40) * 1000 + 200000;

        @(posedge hresetn);
        idle(2);

        // Control register lane writes
        cr_model = '0;
        for (int i = 0; i < 12; i++) begin
            size = 3'(int'(rand_bits(2)) % 3);
            offs = 2'(rand_bits(2));
            if (size == 3'd1) begin
                offs = {offs[1], 1'b0};
            end else if (size == 3'd2) begin
                offs = 2'b00;
            end
            wd = rand_bits(32);
            cr_model = cr_after_write(cr_model, wd, size, offs);
            ahb_write(reg_cr + word_t'(offs), wd, size);
            ahb_read(reg_cr, got);
            check_word("cr", got, cr_model);
        end

        // TIME counts edges since the write ended
        k = 5 + int'(rand_bits(4));
        ahb_write(reg_time, '0, 3'd2);
        idle(k);
        ahb_read(reg_time, got);
        // k idle edges plus the address phase edge
        check_word("time", got, word_t'(k + 1));

        // Delay on its own
        ahb_write(reg_cr, 32'h8000_0001, 3'd2);
        base = packets_seen;
        expect_response(cmd_delay, 8'h00);
        send_byte(cmd_delay);
        send_byte(byte_t'(dly[0]));
        send_byte(8'h00);
        wait_packets(base + 1);
        elapsed = longint'(last_packet_time - accept_time);
        // First microsecond may be partial
        if (elapsed < longint'(dly[0] - 1) * 1000 || elapsed > longint'(dly[0] + 2) * 1000) begin
            $display("Delay of %0d us ended after %0d ns", dly[0], elapsed);
            abort_run();
        end

        // Command handled by the firmware
        base = packets_seen;
        expect_response(8'h05, 8'h00);
        send_byte(8'h05);
        while (!intr) @(negedge hclk);
        @(posedge hclk);
        #1;
        ahb_read(reg_sr, got);
        check_word("sr", got, 32'h8000_0000);
        ahb_read(reg_curcmd, got);
        check_word("curcmd", got, 32'h0000_0005);
        for (int i = 0; i < 3; i++) begin
            b = byte_t'(rand_bits(8));
            in_valid = 1'b1;
            in_data  = b;
            ahb_read(reg_dr, got);
            in_valid = 1'b0;
            in_data  = '0;
            check_word("dr", got, {23'd0, 1'b1, b});
            check_word("dr_wait_states", word_t'(last_wait), 32'd0);
        end
        // Empty stream runs into the timeout
        ahb_read(reg_dr, got);
        check_word("dr", got, 32'h0000_0000);
        check_word("dr_wait_states", word_t'(last_wait), word_t'(dr_timeout_cycles));
        n = 2 + int'(rand_bits(2));
        for (int i = 0; i < n; i++) begin
            b = byte_t'(rand_bits(8));
            expect_write(resp_addr_t'(i), b);
            ahb_write(reg_dr, {24'd0, b}, 3'd2);
        end
        exp_len.push_back(resp_addr_t'(n));
        ahb_write(reg_sr, 32'h8000_0000, 3'd2);
        wait_packets(base + 1);
        if (intr) begin
            fail_with("intr still high after the status register was cleared");
        end

        // Execute Commands with three Delays and an abort
        base = packets_seen;
        expect_response(cmd_execute, 8'd3);
        send_byte(cmd_execute);
        send_byte(8'd3);
        g0 = groups_seen;
        for (int i = 0; i < 3; i++) begin
            if (i == 2) begin
                almost_full = 1'b1;
            end
            expect_response(cmd_delay, 8'h00);
            send_byte(cmd_delay);
            send_byte(byte_t'(dly[i + 1]));
            send_byte(8'h00);
            wait_groups(g0 + 2 * (i + 1));
            idle(3);
            if (i < 2) begin
                check_word("packets", word_t'(packets_seen),
                           word_t'(base + packet_due(i + 1, 3)));
            end
            if (i == 0) begin
                expect_response(cmd_transfer_abort, 8'h00);
                send_byte(cmd_transfer_abort);
            end
        end
        idle(10);
        check_word("packets", word_t'(packets_seen), word_t'(base));
        almost_full = 1'b0;
        wait_packets(base + packet_due(3, 3));

        // Disabled controller ignores the stream
        ahb_write(reg_cr, 32'h0000_0000, 3'd2);
        base = packets_seen;
        in_valid = 1'b1;
        in_data  = cmd_delay;
        repeat (8) begin
            @(negedge hclk);
            if (in_ready) begin
                fail_with("in_ready high while the controller is disabled");
            end
        end
        @(posedge hclk);
        #1;
        in_valid = 1'b0;
        in_data  = '0;
        idle(4);
        check_word("packets", word_t'(packets_seen), word_t'(base));

        if (exp_data.size() != 0 || exp_len.size() != 0) begin
            fail_with("Expected response bytes never appeared");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== all.f ====
src/dap_pkg.sv
src/dap_timer.sv
src/dap_ahb_regs.sv
src/dap_cmd_fsm.sv
src/dap_mcu_helper.sv
src/dap_delay_worker.sv
src/dap_controller.sv
sim/tb_clock_gen.sv
sim/tb_dap_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_dap_controller
FILELIST  ?= all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
